/* hw/sm83_irq_pkg.sv */
// ------------------------------------------------------------
// Interrupt sources, vectors and dispatch sequencing.
// ------------------------------------------------------------

package sm83_irq_pkg;

	// One bit per source, bit 0 (vblank) has highest priority.
	typedef logic [4:0] irq_mask_t;

	// Index of a single source.
	typedef logic [2:0] irq_index_t;

	// Low byte of the jump target.
	typedef logic [7:0] irq_vector_t;

	localparam irq_vector_t VEC_BASE = 8'h40;
	localparam irq_vector_t VEC_STEP = 8'h08;

	// Nothing granted at the sample point.
	localparam irq_vector_t VEC_NONE = 8'h00;

	// One state per M-cycle of the dispatch.
	typedef enum logic [2:0] {
		IDLE,
		WAIT1,
		WAIT2,
		PUSH_HI,
		PUSH_LO,
		JUMP
	} dispatch_state_t;

endpackage

/* hw/sm83_bus_pkg.sv */
// ------------------------------------------------------------
// Register bus as seen by the interrupt unit.
// ------------------------------------------------------------

package sm83_bus_pkg;

	// CPU address space.
	typedef logic [15:0] bus_addr_t;

	// Data byte.
	typedef logic [7:0] bus_data_t;

	// Interrupt flag register, IO page.
	localparam bus_addr_t ADDR_IF = 16'hFF0F;

	// Interrupt enable register, last byte of the map.
	localparam bus_addr_t ADDR_IE = 16'hFFFF;

endpackage

/* hw/sm83_irq_prio_bit.sv */
`timescale 1ns/1ps
`default_nettype none

// One slice of the priority chain.
// The higher_in/higher_out pair is the distributed NOR that tells
// lower slices someone above them is pending. The grant flop takes
// the NAND term, pending and nobody above, at the sample strobe.
module sm83_irq_prio_bit (
	input  logic clk,
	input  logic rst_n,
	input  logic pending,
	input  logic sample,
	input  logic higher_in,
	output logic higher_out,
	output logic grant
);

	logic win;

	// Ripple of "somebody at or above is pending".
	assign higher_out = higher_in | pending;

	// Only the first pending slice wins.
	assign win = pending & ~higher_in;

	// ------------------------------------------------------------
	// Sampled grant, held until the next sample.
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			grant <= 1'b0;
		end else if (sample) begin
			grant <= win;
		end
	end

endmodule

`default_nettype wire

/* hw/sm83_irq_prio_chain.sv */
`timescale 1ns/1ps
`default_nettype none

// Chain of priority slices, slice 0 at the top.
module sm83_irq_prio_chain #(
	parameter int NUM_IRQ = 5
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  sm83_irq_pkg::irq_mask_t  pending,
	input  logic                     sample,
	output sm83_irq_pkg::irq_mask_t  grant,
	output sm83_irq_pkg::irq_index_t grant_index
);

	logic [NUM_IRQ-1:0] higher;
	logic [NUM_IRQ-1:0] slice_grant;

	for (genvar i = 0; i < NUM_IRQ; i++) begin : g_slice
		logic higher_in;

		// Nothing sits above the first slice.
		if (i == 0) begin : g_head
			assign higher_in = 1'b0;
		end else begin : g_link
			assign higher_in = higher[i-1];
		end

		sm83_irq_prio_bit slice_i (
			.clk        (clk),
			.rst_n      (rst_n),
			.pending    (pending[i]),
			.sample     (sample),
			.higher_in  (higher_in),
			.higher_out (higher[i]),
			.grant      (slice_grant[i])
		);
	end

	always_comb begin
		grant = '0;
		grant[NUM_IRQ-1:0] = slice_grant;
	end

	// One-hot to index.
	always_comb begin
		grant_index = '0;
		for (int k = 0; k < NUM_IRQ; k++) begin
			if (slice_grant[k]) begin
				grant_index = sm83_irq_pkg::irq_index_t'(k);
			end
		end
	end

	a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(grant));

endmodule

`default_nettype wire

/* hw/sm83_irq_regs.sv */
`timescale 1ns/1ps
`default_nettype none

// IF and IE registers on the register bus.
module sm83_irq_regs #(
	parameter int NUM_IRQ = 5
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  sm83_irq_pkg::irq_mask_t irq_req,
	input  sm83_bus_pkg::bus_addr_t addr,
	input  sm83_bus_pkg::bus_data_t wdata,
	input  logic                    wr,
	input  logic                    rd,
	input  sm83_irq_pkg::irq_mask_t ack,
	output sm83_bus_pkg::bus_data_t rdata,
	output sm83_irq_pkg::irq_mask_t pending
);

	logic [NUM_IRQ-1:0]      if_q;
	logic [NUM_IRQ-1:0]      if_wr;
	logic [NUM_IRQ-1:0]      if_d;
	sm83_bus_pkg::bus_data_t ie_q;
	sm83_irq_pkg::irq_mask_t if_full;
	logic                    sel_if;
	logic                    sel_ie;

	assign sel_if = addr == sm83_bus_pkg::ADDR_IF;
	assign sel_ie = addr == sm83_bus_pkg::ADDR_IE;

	// ------------------------------------------------------------
	// Flag update: bus write, then ack clear, then new requests.
	// ------------------------------------------------------------
	always_comb begin
		if_wr = if_q;
		if (wr && sel_if) begin
			if_wr = wdata[NUM_IRQ-1:0];
		end
		// A request in the ack cycle keeps its bit set.
		if_d = (if_wr & ~ack[NUM_IRQ-1:0]) | irq_req[NUM_IRQ-1:0];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			if_q <= '0;
			ie_q <= '0;
		end else begin
			if_q <= if_d;
			if (wr && sel_ie) begin
				ie_q <= wdata;
			end
		end
	end

	// Zero-extend to the full source width.
	always_comb begin
		if_full = '0;
		if_full[NUM_IRQ-1:0] = if_q;
	end

	// Pending means flagged and enabled.
	always_comb begin
		pending = '0;
		pending[NUM_IRQ-1:0] = if_q & ie_q[NUM_IRQ-1:0];
	end

	// ------------------------------------------------------------
	// Read mux, IF has its unused top bits tied high.
	// ------------------------------------------------------------
	always_comb begin
		rdata = '0;
		if (rd) begin
			if (sel_if) begin
				rdata = {3'b111, if_full};
			end else if (sel_ie) begin
				rdata = ie_q;
			end
		end
	end

	a_ack_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(ack));

endmodule

`default_nettype wire

/* hw/sm83_irq_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

// Master enable and the five M-cycle interrupt dispatch.
module sm83_irq_dispatch (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      instr_boundary,
	input  logic                      ei,
	input  logic                      di,
	input  sm83_irq_pkg::irq_mask_t   pending,
	input  sm83_irq_pkg::irq_mask_t   grant,
	input  sm83_irq_pkg::irq_index_t  grant_index,
	output logic                      sample,
	output sm83_irq_pkg::irq_mask_t   ack,
	output logic                      dispatch_busy,
	output logic                      vector_valid,
	output sm83_irq_pkg::irq_vector_t vector
);

	sm83_irq_pkg::dispatch_state_t state_q;
	sm83_irq_pkg::dispatch_state_t state_d;
	logic                          ime_q;
	logic                          start;
	logic                          in_jump;

	// Accept only between instructions, with IME set.
	assign start = (state_q == sm83_irq_pkg::IDLE) && instr_boundary &&
		ime_q && (pending != '0);

	// ------------------------------------------------------------
	// Dispatch sequence.
	// ------------------------------------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			sm83_irq_pkg::IDLE: begin
				if (start) begin
					state_d = sm83_irq_pkg::WAIT1;
				end
			end
			sm83_irq_pkg::WAIT1:   state_d = sm83_irq_pkg::WAIT2;
			sm83_irq_pkg::WAIT2:   state_d = sm83_irq_pkg::PUSH_HI;
			sm83_irq_pkg::PUSH_HI: state_d = sm83_irq_pkg::PUSH_LO;
			sm83_irq_pkg::PUSH_LO: state_d = sm83_irq_pkg::JUMP;
			sm83_irq_pkg::JUMP:    state_d = sm83_irq_pkg::IDLE;
			default:               state_d = sm83_irq_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= sm83_irq_pkg::IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// IME drops as the dispatch is accepted.
	// EI and DI only count while idle.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ime_q <= 1'b0;
		end else if (start) begin
			ime_q <= 1'b0;
		end else if (!dispatch_busy) begin
			if (di) begin
				ime_q <= 1'b0;
			end else if (ei) begin
				ime_q <= 1'b1;
			end
		end
	end

	assign dispatch_busy = state_q != sm83_irq_pkg::IDLE;
	assign in_jump       = state_q == sm83_irq_pkg::JUMP;

	// Priority is frozen while the high byte goes out.
	assign sample = state_q == sm83_irq_pkg::PUSH_HI;

	// ------------------------------------------------------------
	// Vector and flag acknowledge.
	// ------------------------------------------------------------
	assign vector_valid = in_jump;
	assign ack          = in_jump ? grant : '0;

	always_comb begin
		vector = sm83_irq_pkg::VEC_NONE;
		if (in_jump && grant != '0) begin
			vector = sm83_irq_pkg::VEC_BASE +
				sm83_irq_pkg::VEC_STEP * sm83_irq_pkg::irq_vector_t'(grant_index);
		end
	end

	// The vector must follow a sample two cycles earlier.
	a_vector_after_sample: assert property (@(posedge clk) disable iff (!rst_n)
		vector_valid |-> state_q == sm83_irq_pkg::JUMP && $past(sample, 2));

	a_ime_low_busy: assert property (@(posedge clk) disable iff (!rst_n)
		dispatch_busy |-> !ime_q);

endmodule

`default_nettype wire

/* hw/sm83_irq_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Interrupt unit, register file plus priority chain plus dispatch.
module sm83_irq_top #(
	parameter int NUM_IRQ = 5
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  sm83_irq_pkg::irq_mask_t   irq_req,
	input  sm83_bus_pkg::bus_addr_t   addr,
	input  sm83_bus_pkg::bus_data_t   wdata,
	input  logic                      wr,
	input  logic                      rd,
	output sm83_bus_pkg::bus_data_t   rdata,
	input  logic                      instr_boundary,
	input  logic                      ei,
	input  logic                      di,
	output logic                      dispatch_busy,
	output logic                      vector_valid,
	output sm83_irq_pkg::irq_vector_t vector
);

	sm83_irq_pkg::irq_mask_t  pending;
	sm83_irq_pkg::irq_mask_t  grant;
	sm83_irq_pkg::irq_mask_t  ack;
	sm83_irq_pkg::irq_index_t grant_index;
	logic                     sample;

	sm83_irq_regs #(.NUM_IRQ(NUM_IRQ)) regs_i (
		.clk(clk), .rst_n(rst_n), .irq_req(irq_req), .addr(addr), .wdata(wdata),
		.wr(wr), .rd(rd), .ack(ack), .rdata(rdata), .pending(pending)
	);

	sm83_irq_prio_chain #(.NUM_IRQ(NUM_IRQ)) chain_i (
		.clk(clk), .rst_n(rst_n), .pending(pending), .sample(sample),
		.grant(grant), .grant_index(grant_index)
	);

	sm83_irq_dispatch dispatch_i (
		.clk(clk), .rst_n(rst_n), .instr_boundary(instr_boundary), .ei(ei), .di(di),
		.pending(pending), .grant(grant), .grant_index(grant_index), .sample(sample),
		.ack(ack), .dispatch_busy(dispatch_busy), .vector_valid(vector_valid),
		.vector(vector)
	);

endmodule

`default_nettype wire

/* tb/sm83_irq_tb.sv */
`timescale 1ns/1ps

module sm83_irq_tb;

	localparam int RESET_CYCLES = 16;
	// Rough cycle counts of the six tests, in order.
	localparam int TEST_CYCLES = 12 + 70 + 60 + 60 + 50 + 30;
	localparam int WATCHDOG_NS = (RESET_CYCLES + TEST_CYCLES + 200) * 10;

	logic clk, rst_n, wr, rd, instr_boundary, ei, di;
	logic dispatch_busy, vector_valid;
	logic [4:0] irq_req;
	logic [15:0] addr;
	logic [7:0] wdata, rdata, vector;

	// Reference model state.
	logic [4:0] ref_if, ref_grant, ref_pending, ref_ack, ref_if_wr;
	logic [7:0] ref_ie, exp_rdata, exp_vector;
	logic [2:0] ref_cnt;
	logic ref_ime, ref_start, exp_busy, exp_valid;

	int seed = 51;
	int errors = 0;
	int test_errors = 0;
	int test_num = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	sm83_irq_top #(.NUM_IRQ(5)) dut_i (
		.clk(clk), .rst_n(rst_n), .irq_req(irq_req), .addr(addr), .wdata(wdata),
		.wr(wr), .rd(rd), .rdata(rdata), .instr_boundary(instr_boundary), .ei(ei),
		.di(di), .dispatch_busy(dispatch_busy), .vector_valid(vector_valid), .vector(vector)
	);

	always #5 clk = ~clk;

	// Lowest set bit wins.
	function automatic logic [4:0] first_pending(input logic [4:0] mask);
		logic [4:0] r;
		r = '0;
		for (int k = 4; k >= 0; k--) begin
			if (mask[k]) begin
				r = '0;
				r[k] = 1'b1;
			end
		end
		return r;
	endfunction

	function automatic logic [7:0] vector_for(input logic [4:0] onehot);
		logic [7:0] v;
		v = 8'h00;
		for (int k = 0; k < 5; k++) begin
			if (onehot[k]) begin
				v = 8'h40 + 8'(8 * k);
			end
		end
		return v;
	endfunction

	// ------------------------------------------------------------
	// Reference model of IF, IE, IME and the dispatch count.
	// ------------------------------------------------------------
	always_comb begin
		ref_pending = ref_if & ref_ie[4:0];
		ref_start = (ref_cnt == 3'd0) && instr_boundary && ref_ime && (ref_pending != '0);
		ref_ack = (ref_cnt == 3'd5) ? ref_grant : '0;
		ref_if_wr = (wr && addr == sm83_bus_pkg::ADDR_IF) ? wdata[4:0] : ref_if;
		exp_busy = ref_cnt != 3'd0;
		exp_valid = ref_cnt == 3'd5;
		exp_vector = vector_for(ref_grant);
		exp_rdata = 8'h00;
		if (rd && addr == sm83_bus_pkg::ADDR_IF) begin
			exp_rdata = {3'b111, ref_if};
		end else if (rd && addr == sm83_bus_pkg::ADDR_IE) begin
			exp_rdata = ref_ie;
		end
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ref_if <= '0;
			ref_ie <= '0;
			ref_ime <= 1'b0;
			ref_cnt <= '0;
			ref_grant <= '0;
		end else begin
			ref_if <= (ref_if_wr & ~ref_ack) | irq_req;
			if (wr && addr == sm83_bus_pkg::ADDR_IE) begin
				ref_ie <= wdata;
			end
			if (ref_start || (!exp_busy && di)) begin
				ref_ime <= 1'b0;
			end else if (!exp_busy && ei) begin
				ref_ime <= 1'b1;
			end
			if (ref_start) begin
				ref_cnt <= 3'd1;
			end else if (exp_busy) begin
				ref_cnt <= (ref_cnt == 3'd5) ? 3'd0 : ref_cnt + 3'd1;
			end
			// Grant is taken in PUSH_HI.
			if (ref_cnt == 3'd3) begin
				ref_grant <= first_pending(ref_pending);
			end
		end
	end

	task automatic report_mismatch(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		$display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
		errors++;
	endtask

	a_rdata: assert property (@(posedge clk) disable iff (!rst_n) rdata == exp_rdata)
		else report_mismatch("rdata", $sampled(exp_rdata), $sampled(rdata));
	a_busy: assert property (@(posedge clk) disable iff (!rst_n) dispatch_busy == exp_busy)
		else report_mismatch("dispatch_busy", 8'($sampled(exp_busy)),
			8'($sampled(dispatch_busy)));
	a_valid: assert property (@(posedge clk) disable iff (!rst_n) vector_valid == exp_valid)
		else report_mismatch("vector_valid", 8'($sampled(exp_valid)),
			8'($sampled(vector_valid)));
	a_vector: assert property (@(posedge clk) disable iff (!rst_n)
		exp_valid |-> vector == exp_vector)
		else report_mismatch("vector", $sampled(exp_vector), $sampled(vector));
	a_ime: assert property (@(posedge clk) disable iff (!rst_n)
		dut_i.dispatch_i.ime_q == ref_ime)
		else report_mismatch("ime", 8'($sampled(ref_ime)),
			8'($sampled(dut_i.dispatch_i.ime_q)));

	// ------------------------------------------------------------
	// Stimulus helpers.
	// ------------------------------------------------------------
	task automatic step_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic write_reg(input logic [15:0] a, input logic [7:0] d);
		addr = a;
		wdata = d;
		wr = 1'b1;
		step_cycle();
		wr = 1'b0;
	endtask

	task automatic read_reg(input logic [15:0] a);
		addr = a;
		rd = 1'b1;
		step_cycle();
		rd = 1'b0;
	endtask

	task automatic pulse_ei();
		ei = 1'b1;
		step_cycle();
		ei = 1'b0;
	endtask

	task automatic pulse_di();
		di = 1'b1;
		step_cycle();
		di = 1'b0;
	endtask

	task automatic pulse_boundary();
		instr_boundary = 1'b1;
		step_cycle();
		instr_boundary = 1'b0;
	endtask

	// Waits for the JUMP cycle; req is raised in that same cycle.
	task automatic wait_vector(input logic [4:0] req);
		int n;
		n = 0;
		while (!vector_valid && n < 10) begin
			step_cycle();
			n++;
		end
		if (!vector_valid) begin
			$display("ERROR: no vector_valid within 10 cycles at %0t", $time);
			errors++;
		end else begin
			irq_req = req;
			step_cycle();
			irq_req = '0;
		end
	endtask

	task automatic expect_quiet(input int cycles);
		int seen;
		seen = 0;
		repeat (cycles) begin
			if (dispatch_busy || vector_valid) begin
				seen = 1;
			end
			step_cycle();
		end
		if (seen != 0) begin
			$display("ERROR: dispatch started although it should not at %0t", $time);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		test_num++;
		if (errors == test_errors) begin
			tests_passed++;
			$display("test %0d %s: pass", test_num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: fail, %0d errors", test_num, name, errors - test_errors);
		end
		test_errors = errors;
	endtask

	// ------------------------------------------------------------
	// Tests.
	// ------------------------------------------------------------
	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		irq_req = '0;
		addr = '0;
		wdata = '0;
		wr = 1'b0;
		rd = 1'b0;
		instr_boundary = 1'b0;
		ei = 1'b0;
		di = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		step_cycle();

		write_reg(sm83_bus_pkg::ADDR_IF, 8'h1A);
		read_reg(sm83_bus_pkg::ADDR_IF);
		write_reg(sm83_bus_pkg::ADDR_IE, 8'hA5);
		read_reg(sm83_bus_pkg::ADDR_IE);
		end_test("register readback");

		for (int i = 0; i < 20; i++) begin
			irq_req = 5'($random(seed));
			step_cycle();
			irq_req = '0;
			read_reg(sm83_bus_pkg::ADDR_IF);
			if (i % 5 == 4) begin
				write_reg(sm83_bus_pkg::ADDR_IF, 8'($random(seed)));
			end
		end
		end_test("random requests");

		write_reg(sm83_bus_pkg::ADDR_IE, 8'h1F);
		write_reg(sm83_bus_pkg::ADDR_IF, 8'h16);
		pulse_ei();
		pulse_boundary();
		wait_vector('0);
		read_reg(sm83_bus_pkg::ADDR_IF);
		// IME is now clear, so the next source has to wait.
		pulse_boundary();
		expect_quiet(8);
		pulse_ei();
		pulse_boundary();
		wait_vector('0);
		read_reg(sm83_bus_pkg::ADDR_IF);
		end_test("priority dispatch");

		write_reg(sm83_bus_pkg::ADDR_IF, 8'h03);
		pulse_boundary();
		expect_quiet(8);
		pulse_ei();
		pulse_di();
		pulse_boundary();
		expect_quiet(8);
		write_reg(sm83_bus_pkg::ADDR_IE, 8'h00);
		pulse_ei();
		pulse_boundary();
		expect_quiet(8);
		pulse_di();
		write_reg(sm83_bus_pkg::ADDR_IE, 8'h1F);
		end_test("no dispatch when masked");

		write_reg(sm83_bus_pkg::ADDR_IF, 8'h04);
		pulse_ei();
		pulse_boundary();
		write_reg(sm83_bus_pkg::ADDR_IF, 8'h00);
		wait_vector('0);
		write_reg(sm83_bus_pkg::ADDR_IF, 8'h08);
		pulse_ei();
		pulse_boundary();
		step_cycle();
		// Vblank arrives during WAIT2.
		irq_req = 5'h01;
		step_cycle();
		irq_req = '0;
		wait_vector('0);
		read_reg(sm83_bus_pkg::ADDR_IF);
		end_test("late change before sample");

		write_reg(sm83_bus_pkg::ADDR_IF, 8'h02);
		pulse_ei();
		pulse_boundary();
		wait_vector(5'h02);
		read_reg(sm83_bus_pkg::ADDR_IF);
		write_reg(sm83_bus_pkg::ADDR_IF, 8'h00);
		end_test("ack and request collide");

		$display("tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
			errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("ERROR: watchdog expired after %0d ns", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

endmodule

/* flist.f */
hw/sm83_irq_pkg.sv
hw/sm83_bus_pkg.sv
hw/sm83_irq_prio_bit.sv
hw/sm83_irq_prio_chain.sv
hw/sm83_irq_regs.sv
hw/sm83_irq_dispatch.sv
hw/sm83_irq_top.sv
tb/sm83_irq_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the interrupt unit testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	--top-module sm83_irq_tb -f flist.f -Mdir obj_dir -o sm83_irq_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/sm83_irq_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "Test completed successfully"; then
	exit 0
fi
exit 1
